/* src/rv32i_types_pkg.sv */
`default_nettype none

package rv32i_types_pkg;

    // major opcodes handled by the slice.
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode;

    // follows funct3, except that sub and sra reuse the slt and sltu codes.
    typedef enum logic [2:0] {
        op_add = 3'b000,
        op_sll = 3'b001,
        op_sra = 3'b010,
        op_sub = 3'b011,
        op_xor = 3'b100,
        op_srl = 3'b101,
        op_or  = 3'b110,
        op_and = 3'b111
    } alu_ops;

    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_t;

endpackage

`default_nettype wire

/* src/rv32i_mux_pkg.sv */
`default_nettype none

package rv32i_mux_pkg;

    typedef enum logic {alu1_rs1, alu1_pc} alumux1_sel_t;

    typedef enum logic [2:0] {
        alu2_rs2, alu2_i_imm, alu2_u_imm, alu2_b_imm, alu2_j_imm
    } alumux2_sel_t;

    // second compare operand, rs2 for branches and slt, i_imm for slti.
    typedef enum logic {cmp_rs2, cmp_i_imm} cmpmux_sel_t;

    typedef enum logic [1:0] {
        rf_alu_out, rf_br_en, rf_u_imm, rf_pc_plus4
    } regfilemux_sel_t;

endpackage

`default_nettype wire

/* src/regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module regfile #(
    parameter int data_width = 32,
    parameter int reg_count  = 32
) (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic                         we,
    input  wire logic [$clog2(reg_count)-1:0] waddr,
    input  wire logic [data_width-1:0]        wdata,
    input  wire logic [$clog2(reg_count)-1:0] raddr1,
    input  wire logic [$clog2(reg_count)-1:0] raddr2,
    output logic      [data_width-1:0]        rdata1,
    output logic      [data_width-1:0]        rdata2
);

    logic [data_width-1:0] regs [reg_count];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // a write in the same cycle is seen by the reader at once.
    assign rdata1 = (we && waddr != '0 && waddr == raddr1) ? wdata : regs[raddr1];
    assign rdata2 = (we && waddr != '0 && waddr == raddr2) ? wdata : regs[raddr2];

endmodule

`default_nettype wire

/* src/decode.sv */
`timescale 1ns/1ns
`default_nettype none

module decode #(
    parameter int data_width = 32,
    parameter int reg_count  = 32
) (
    input  wire logic [31:0]                          ins_word,
    input  wire logic [data_width-1:0]                ins_pc,
    input  wire logic [data_width-1:0]                rdata1,
    input  wire logic [data_width-1:0]                rdata2,
    output logic      [$clog2(reg_count)-1:0]         raddr1,
    output logic      [$clog2(reg_count)-1:0]         raddr2,
    output logic      [data_width-1:0]                rs1_data,
    output logic      [data_width-1:0]                rs2_data,
    output logic      [4:0]                           rs1_addr,
    output logic      [4:0]                           rs2_addr,
    output logic      [data_width-1:0]                i_imm,
    output logic      [data_width-1:0]                s_imm,
    output logic      [data_width-1:0]                b_imm,
    output logic      [data_width-1:0]                u_imm,
    output logic      [data_width-1:0]                j_imm,
    output rv32i_types_pkg::rv32i_opcode              opcode,
    output rv32i_types_pkg::alu_ops                   aluop,
    output rv32i_mux_pkg::alumux1_sel_t               alumux1_sel,
    output rv32i_mux_pkg::alumux2_sel_t               alumux2_sel,
    output rv32i_mux_pkg::cmpmux_sel_t                cmpmux_sel,
    output rv32i_mux_pkg::regfilemux_sel_t            regfilemux_sel,
    output logic                                      load_regfile,
    output logic      [4:0]                           rd,
    output logic      [2:0]                           funct3,
    output logic      [data_width-1:0]                pc
);

    localparam int addr_w = $clog2(reg_count);

    logic sign;

    assign sign     = ins_word[31];
    assign raddr1   = ins_word[15 +: addr_w];
    assign raddr2   = ins_word[20 +: addr_w];
    assign rs1_data = rdata1;
    assign rs2_data = rdata2;
    assign rs1_addr = ins_word[19:15];
    assign rs2_addr = ins_word[24:20];
    assign rd       = ins_word[11:7];
    assign funct3   = ins_word[14:12];
    assign pc       = ins_pc;
    assign opcode   = rv32i_types_pkg::rv32i_opcode'(ins_word[6:0]);

    assign i_imm = {{(data_width-12){sign}}, ins_word[31:20]};
    assign s_imm = {{(data_width-12){sign}}, ins_word[31:25], ins_word[11:7]};
    assign b_imm = {{(data_width-13){sign}}, ins_word[31], ins_word[7],
                    ins_word[30:25], ins_word[11:8], 1'b0};
    assign u_imm = {{(data_width-32){sign}}, ins_word[31:12], 12'h000};
    assign j_imm = {{(data_width-21){sign}}, ins_word[31], ins_word[19:12],
                    ins_word[20], ins_word[30:21], 1'b0};

    always_comb begin
        aluop          = rv32i_types_pkg::op_add;
        alumux1_sel    = rv32i_mux_pkg::alu1_rs1;
        alumux2_sel    = rv32i_mux_pkg::alu2_i_imm;
        cmpmux_sel     = rv32i_mux_pkg::cmp_rs2;
        regfilemux_sel = rv32i_mux_pkg::rf_alu_out;
        load_regfile   = 1'b1;
        case (opcode)
            rv32i_types_pkg::op_lui: regfilemux_sel = rv32i_mux_pkg::rf_u_imm;
            rv32i_types_pkg::op_auipc: begin
                alumux1_sel = rv32i_mux_pkg::alu1_pc;
                alumux2_sel = rv32i_mux_pkg::alu2_u_imm;
            end
            rv32i_types_pkg::op_jal: begin
                alumux1_sel    = rv32i_mux_pkg::alu1_pc;
                alumux2_sel    = rv32i_mux_pkg::alu2_j_imm;
                regfilemux_sel = rv32i_mux_pkg::rf_pc_plus4;
            end
            rv32i_types_pkg::op_jalr: regfilemux_sel = rv32i_mux_pkg::rf_pc_plus4;
            rv32i_types_pkg::op_br: begin
                alumux1_sel  = rv32i_mux_pkg::alu1_pc;
                alumux2_sel  = rv32i_mux_pkg::alu2_b_imm;
                load_regfile = 1'b0;
            end
            rv32i_types_pkg::op_imm, rv32i_types_pkg::op_reg: begin
                aluop = rv32i_types_pkg::alu_ops'(funct3);
                if (opcode == rv32i_types_pkg::op_reg) begin
                    alumux2_sel = rv32i_mux_pkg::alu2_rs2;
                end else begin
                    cmpmux_sel = rv32i_mux_pkg::cmp_i_imm;
                end
                // funct7 bit 5 picks sub (register form only) and sra.
                if (funct3 == 3'b000 && ins_word[30] && opcode == rv32i_types_pkg::op_reg) begin
                    aluop = rv32i_types_pkg::op_sub;
                end
                if (funct3 == 3'b101 && ins_word[30]) begin
                    aluop = rv32i_types_pkg::op_sra;
                end
                if (funct3 == 3'b010 || funct3 == 3'b011) begin
                    regfilemux_sel = rv32i_mux_pkg::rf_br_en;
                end
            end
            default: load_regfile = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* src/id_ex.sv */
`timescale 1ns/1ns
`default_nettype none

module id_ex #(
    parameter int data_width = 32
) (
    input  wire logic                              clk,
    input  wire logic                              rst,
    input  wire logic                              load,
    input  wire logic                              flush,
    input  wire logic                              drain,
    input  wire logic [data_width-1:0]             rs1_data_in,
    input  wire logic [data_width-1:0]             rs2_data_in,
    input  wire logic [4:0]                        rs1_addr_in,
    input  wire logic [4:0]                        rs2_addr_in,
    input  wire logic [data_width-1:0]             i_imm_in,
    input  wire logic [data_width-1:0]             s_imm_in,
    input  wire logic [data_width-1:0]             b_imm_in,
    input  wire logic [data_width-1:0]             u_imm_in,
    input  wire logic [data_width-1:0]             j_imm_in,
    input  rv32i_types_pkg::rv32i_opcode           opcode_in,
    input  rv32i_types_pkg::alu_ops                aluop_in,
    input  rv32i_mux_pkg::alumux1_sel_t            alumux1_sel_in,
    input  rv32i_mux_pkg::alumux2_sel_t            alumux2_sel_in,
    input  rv32i_mux_pkg::cmpmux_sel_t             cmpmux_sel_in,
    input  rv32i_mux_pkg::regfilemux_sel_t         regfilemux_sel_in,
    input  wire logic                              load_regfile_in,
    input  wire logic [4:0]                        rd_in,
    input  wire logic [2:0]                        funct3_in,
    input  wire logic [data_width-1:0]             pc_in,
    output logic      [data_width-1:0]             rs1_data,
    output logic      [data_width-1:0]             rs2_data,
    output logic      [4:0]                        rs1_addr,
    output logic      [4:0]                        rs2_addr,
    output logic      [data_width-1:0]             i_imm,
    output logic      [data_width-1:0]             s_imm,
    output logic      [data_width-1:0]             b_imm,
    output logic      [data_width-1:0]             u_imm,
    output logic      [data_width-1:0]             j_imm,
    output rv32i_types_pkg::rv32i_opcode           opcode,
    output rv32i_types_pkg::alu_ops                aluop,
    output rv32i_mux_pkg::alumux1_sel_t            alumux1_sel,
    output rv32i_mux_pkg::alumux2_sel_t            alumux2_sel,
    output rv32i_mux_pkg::cmpmux_sel_t             cmpmux_sel,
    output rv32i_mux_pkg::regfilemux_sel_t         regfilemux_sel,
    output logic                                   load_regfile,
    output logic      [4:0]                        rd,
    output logic      [2:0]                        funct3,
    output logic      [data_width-1:0]             pc,
    output logic                                   valid
);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            // bubble is an addi x0 that never writes back.
            valid          <= 1'b0;
            rs1_data       <= '0;
            rs2_data       <= '0;
            rs1_addr       <= '0;
            rs2_addr       <= '0;
            i_imm          <= '0;
            s_imm          <= '0;
            b_imm          <= '0;
            u_imm          <= '0;
            j_imm          <= '0;
            opcode         <= rv32i_types_pkg::op_imm;
            aluop          <= rv32i_types_pkg::op_add;
            alumux1_sel    <= rv32i_mux_pkg::alu1_rs1;
            alumux2_sel    <= rv32i_mux_pkg::alu2_i_imm;
            cmpmux_sel     <= rv32i_mux_pkg::cmp_rs2;
            regfilemux_sel <= rv32i_mux_pkg::rf_pc_plus4;
            load_regfile   <= 1'b0;
            rd             <= '0;
            funct3         <= '0;
            pc             <= '0;
        end else if (load) begin
            valid          <= 1'b1;
            rs1_data       <= rs1_data_in;
            rs2_data       <= rs2_data_in;
            rs1_addr       <= rs1_addr_in;
            rs2_addr       <= rs2_addr_in;
            i_imm          <= i_imm_in;
            s_imm          <= s_imm_in;
            b_imm          <= b_imm_in;
            u_imm          <= u_imm_in;
            j_imm          <= j_imm_in;
            opcode         <= opcode_in;
            aluop          <= aluop_in;
            alumux1_sel    <= alumux1_sel_in;
            alumux2_sel    <= alumux2_sel_in;
            cmpmux_sel     <= cmpmux_sel_in;
            regfilemux_sel <= regfilemux_sel_in;
            load_regfile   <= load_regfile_in;
            rd             <= rd_in;
            funct3         <= funct3_in;
            pc             <= pc_in;
        end else if (drain) begin
            valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* src/execute.sv */
`timescale 1ns/1ns
`default_nettype none

module execute #(
    parameter int data_width = 32
) (
    input  wire logic [data_width-1:0]            rs1_data,
    input  wire logic [data_width-1:0]            rs2_data,
    input  wire logic [data_width-1:0]            i_imm,
    input  wire logic [data_width-1:0]            b_imm,
    input  wire logic [data_width-1:0]            u_imm,
    input  wire logic [data_width-1:0]            j_imm,
    input  rv32i_types_pkg::rv32i_opcode          opcode,
    input  rv32i_types_pkg::alu_ops               aluop,
    input  rv32i_mux_pkg::alumux1_sel_t           alumux1_sel,
    input  rv32i_mux_pkg::alumux2_sel_t           alumux2_sel,
    input  rv32i_mux_pkg::cmpmux_sel_t            cmpmux_sel,
    input  rv32i_mux_pkg::regfilemux_sel_t        regfilemux_sel,
    input  wire logic [2:0]                       funct3,
    input  wire logic [data_width-1:0]            pc,
    input  wire logic                             valid,
    output logic      [data_width-1:0]            res_value,
    output logic                                  res_taken,
    output logic      [data_width-1:0]            res_target,
    output logic                                  redirect
);

    localparam int sh_w = $clog2(data_width);

    logic [data_width-1:0] alu_a;
    logic [data_width-1:0] alu_b;
    logic [data_width-1:0] alu_out;
    logic [data_width-1:0] cmp_b;
    logic                  br_en;
    rv32i_types_pkg::branch_funct3_t cmpop;

    assign alu_a = (alumux1_sel == rv32i_mux_pkg::alu1_pc) ? pc : rs1_data;
    assign cmp_b = (cmpmux_sel == rv32i_mux_pkg::cmp_i_imm) ? i_imm : rs2_data;

    always_comb begin
        case (alumux2_sel)
            rv32i_mux_pkg::alu2_rs2:   alu_b = rs2_data;
            rv32i_mux_pkg::alu2_u_imm: alu_b = u_imm;
            rv32i_mux_pkg::alu2_b_imm: alu_b = b_imm;
            rv32i_mux_pkg::alu2_j_imm: alu_b = j_imm;
            default:                   alu_b = i_imm;
        endcase
    end

    always_comb begin
        case (aluop)
            rv32i_types_pkg::op_sll: alu_out = alu_a << alu_b[sh_w-1:0];
            rv32i_types_pkg::op_sra: alu_out = $signed(alu_a) >>> alu_b[sh_w-1:0];
            rv32i_types_pkg::op_sub: alu_out = alu_a - alu_b;
            rv32i_types_pkg::op_xor: alu_out = alu_a ^ alu_b;
            rv32i_types_pkg::op_srl: alu_out = alu_a >> alu_b[sh_w-1:0];
            rv32i_types_pkg::op_or:  alu_out = alu_a | alu_b;
            rv32i_types_pkg::op_and: alu_out = alu_a & alu_b;
            default:                 alu_out = alu_a + alu_b;
        endcase
    end

    // slt and sltu share the signed and unsigned less-than compares.
    always_comb begin
        case (funct3)
            3'b010:  cmpop = rv32i_types_pkg::blt;
            3'b011:  cmpop = rv32i_types_pkg::bltu;
            default: cmpop = rv32i_types_pkg::branch_funct3_t'(funct3);
        endcase
        case (cmpop)
            rv32i_types_pkg::bne:  br_en = rs1_data != cmp_b;
            rv32i_types_pkg::blt:  br_en = $signed(rs1_data) < $signed(cmp_b);
            rv32i_types_pkg::bge:  br_en = $signed(rs1_data) >= $signed(cmp_b);
            rv32i_types_pkg::bltu: br_en = rs1_data < cmp_b;
            rv32i_types_pkg::bgeu: br_en = rs1_data >= cmp_b;
            default:               br_en = rs1_data == cmp_b;
        endcase
    end

    always_comb begin
        case (regfilemux_sel)
            rv32i_mux_pkg::rf_br_en:    res_value = {{(data_width-1){1'b0}}, br_en};
            rv32i_mux_pkg::rf_u_imm:    res_value = u_imm;
            rv32i_mux_pkg::rf_pc_plus4: res_value = pc + data_width'(4);
            default:                    res_value = alu_out;
        endcase
    end

    assign res_taken = (opcode == rv32i_types_pkg::op_br && br_en) ||
                       opcode == rv32i_types_pkg::op_jal ||
                       opcode == rv32i_types_pkg::op_jalr;
    assign res_target = (opcode == rv32i_types_pkg::op_jalr) ?
                        {alu_out[data_width-1:1], 1'b0} : alu_out;
    assign redirect = res_taken && valid;

endmodule

`default_nettype wire

/* src/rv32i_slice.sv */
`timescale 1ns/1ns
`default_nettype none

module rv32i_slice #(
    parameter int data_width = 32,
    parameter int reg_count  = 32
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  ins_valid,
    output logic                       ins_ready,
    input  wire logic [31:0]           ins_word,
    input  wire logic [data_width-1:0] ins_pc,
    output logic                       res_valid,
    input  wire logic                  res_ready,
    output logic      [4:0]            res_rd,
    output logic      [data_width-1:0] res_value,
    output logic                       res_we,
    output logic                       res_taken,
    output logic      [data_width-1:0] res_target
);

    localparam int addr_w = $clog2(reg_count);

    logic [addr_w-1:0]     raddr1;
    logic [addr_w-1:0]     raddr2;
    logic [data_width-1:0] rdata1;
    logic [data_width-1:0] rdata2;
    logic                  res_fire;
    logic                  ins_fire;
    logic                  redirect;

    // decode outputs.
    logic [data_width-1:0] d_rs1_data, d_rs2_data, d_pc;
    logic [data_width-1:0] d_i_imm, d_s_imm, d_b_imm, d_u_imm, d_j_imm;
    logic [4:0]            d_rs1_addr, d_rs2_addr, d_rd;
    logic [2:0]            d_funct3;
    logic                  d_load_regfile;
    rv32i_types_pkg::rv32i_opcode     d_opcode;
    rv32i_types_pkg::alu_ops          d_aluop;
    rv32i_mux_pkg::alumux1_sel_t      d_alumux1_sel;
    rv32i_mux_pkg::alumux2_sel_t      d_alumux2_sel;
    rv32i_mux_pkg::cmpmux_sel_t       d_cmpmux_sel;
    rv32i_mux_pkg::regfilemux_sel_t   d_regfilemux_sel;

    // id_ex outputs.
    logic [data_width-1:0] e_rs1_data, e_rs2_data, e_pc;
    logic [data_width-1:0] e_i_imm, e_b_imm, e_u_imm, e_j_imm;
    logic [2:0]            e_funct3;
    rv32i_types_pkg::rv32i_opcode     e_opcode;
    rv32i_types_pkg::alu_ops          e_aluop;
    rv32i_mux_pkg::alumux1_sel_t      e_alumux1_sel;
    rv32i_mux_pkg::alumux2_sel_t      e_alumux2_sel;
    rv32i_mux_pkg::cmpmux_sel_t       e_cmpmux_sel;
    rv32i_mux_pkg::regfilemux_sel_t   e_regfilemux_sel;

    assign res_fire = res_valid && res_ready;
    // nothing new enters behind a taken redirect that is leaving.
    assign ins_ready = !res_valid || (res_ready && !redirect);
    assign ins_fire = ins_valid && ins_ready;

    regfile #(.data_width(data_width), .reg_count(reg_count)) regfile_inst (
        .clk(clk), .rst(rst),
        .we(res_fire && res_we), .waddr(res_rd[addr_w-1:0]), .wdata(res_value),
        .raddr1(raddr1), .raddr2(raddr2), .rdata1(rdata1), .rdata2(rdata2)
    );

    decode #(.data_width(data_width), .reg_count(reg_count)) decode_inst (
        .ins_word(ins_word), .ins_pc(ins_pc), .rdata1(rdata1), .rdata2(rdata2),
        .raddr1(raddr1), .raddr2(raddr2),
        .rs1_data(d_rs1_data), .rs2_data(d_rs2_data),
        .rs1_addr(d_rs1_addr), .rs2_addr(d_rs2_addr),
        .i_imm(d_i_imm), .s_imm(d_s_imm), .b_imm(d_b_imm), .u_imm(d_u_imm), .j_imm(d_j_imm),
        .opcode(d_opcode), .aluop(d_aluop),
        .alumux1_sel(d_alumux1_sel), .alumux2_sel(d_alumux2_sel),
        .cmpmux_sel(d_cmpmux_sel), .regfilemux_sel(d_regfilemux_sel),
        .load_regfile(d_load_regfile), .rd(d_rd), .funct3(d_funct3), .pc(d_pc)
    );

    id_ex #(.data_width(data_width)) id_ex_inst (
        .clk(clk), .rst(rst),
        .load(ins_fire), .flush(res_fire && redirect), .drain(res_fire),
        .rs1_data_in(d_rs1_data), .rs2_data_in(d_rs2_data),
        .rs1_addr_in(d_rs1_addr), .rs2_addr_in(d_rs2_addr),
        .i_imm_in(d_i_imm), .s_imm_in(d_s_imm), .b_imm_in(d_b_imm),
        .u_imm_in(d_u_imm), .j_imm_in(d_j_imm),
        .opcode_in(d_opcode), .aluop_in(d_aluop),
        .alumux1_sel_in(d_alumux1_sel), .alumux2_sel_in(d_alumux2_sel),
        .cmpmux_sel_in(d_cmpmux_sel), .regfilemux_sel_in(d_regfilemux_sel),
        .load_regfile_in(d_load_regfile), .rd_in(d_rd), .funct3_in(d_funct3), .pc_in(d_pc),
        .rs1_data(e_rs1_data), .rs2_data(e_rs2_data), .rs1_addr(), .rs2_addr(),
        .i_imm(e_i_imm), .s_imm(), .b_imm(e_b_imm), .u_imm(e_u_imm), .j_imm(e_j_imm),
        .opcode(e_opcode), .aluop(e_aluop),
        .alumux1_sel(e_alumux1_sel), .alumux2_sel(e_alumux2_sel),
        .cmpmux_sel(e_cmpmux_sel), .regfilemux_sel(e_regfilemux_sel),
        .load_regfile(res_we), .rd(res_rd), .funct3(e_funct3), .pc(e_pc), .valid(res_valid)
    );

    execute #(.data_width(data_width)) execute_inst (
        .rs1_data(e_rs1_data), .rs2_data(e_rs2_data),
        .i_imm(e_i_imm), .b_imm(e_b_imm), .u_imm(e_u_imm), .j_imm(e_j_imm),
        .opcode(e_opcode), .aluop(e_aluop),
        .alumux1_sel(e_alumux1_sel), .alumux2_sel(e_alumux2_sel),
        .cmpmux_sel(e_cmpmux_sel), .regfilemux_sel(e_regfilemux_sel),
        .funct3(e_funct3), .pc(e_pc), .valid(res_valid),
        .res_value(res_value), .res_taken(res_taken), .res_target(res_target),
        .redirect(redirect)
    );

endmodule

`default_nettype wire

/* testbench/rv32i_slice_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module rv32i_slice_tb;

    localparam int max_lines = 64;
    localparam int fields    = 7;

    logic        clk;
    logic        rst;
    logic        ins_valid;
    logic        ins_ready;
    logic [31:0] ins_word;
    logic [31:0] ins_pc;
    logic        res_valid;
    logic        res_ready;
    logic [4:0]  res_rd;
    logic [31:0] res_value;
    logic        res_we;
    logic        res_taken;
    logic [31:0] res_target;

    // one pattern line is seven consecutive words.
    logic [31:0] patterns [0:max_lines*fields-1];
    int line_count;
    int received;
    int errors;
    int cycles;
    int cycle_limit;

    rv32i_slice #(.data_width(32), .reg_count(32)) rv32i_slice_inst (
        .clk(clk), .rst(rst),
        .ins_valid(ins_valid), .ins_ready(ins_ready), .ins_word(ins_word), .ins_pc(ins_pc),
        .res_valid(res_valid), .res_ready(res_ready), .res_rd(res_rd),
        .res_value(res_value), .res_we(res_we), .res_taken(res_taken),
        .res_target(res_target)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input string field, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t: result %0d %s is %h, expected %h",
                     $time, received, field, got, expected);
        end
    endtask

    task automatic compare_result();
        int base;
        base = received * fields;
        if (received >= line_count) begin
            errors++;
            $display("Unexpected extra result at %0t after all %0d expected results",
                     $time, line_count);
        end else begin
            check_value("we", {31'b0, res_we}, patterns[base+4]);
            check_value("taken", {31'b0, res_taken}, patterns[base+5]);
            if (patterns[base+4][0]) begin
                check_value("rd", {27'b0, res_rd}, patterns[base+2]);
                check_value("value", res_value, patterns[base+3]);
            end
            if (patterns[base+5][0]) begin
                check_value("target", res_target, patterns[base+6]);
            end
            received++;
        end
    endtask

    task automatic report_and_finish();
        $display("results checked: %0d of %0d, errors: %0d", received, line_count, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    // consumer side with random back-pressure.
    task automatic drive_back_pressure();
        forever begin
            @(posedge clk);
            res_ready <= ($urandom_range(3) != 0);
        end
    endtask

    always @(posedge clk) begin
        if (res_valid && res_ready) begin
            compare_result();
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            errors++;
            $display("Timeout after %0d cycles with %0d of %0d results received",
                     cycles, received, line_count);
            report_and_finish();
        end
    end

    initial begin
        int gap;
        rst         = 1'b1;
        ins_valid   = 1'b0;
        ins_word    = '0;
        ins_pc      = '0;
        res_ready   = 1'b0;
        received    = 0;
        errors      = 0;
        cycles      = 0;
        cycle_limit = 0;
        line_count  = 0;
        void'($urandom(99166));
        $readmemh("testbench/rv32i_slice_patterns.txt", patterns);
        while (line_count < max_lines && !$isunknown(patterns[line_count*fields])) begin
            line_count++;
        end
        if (line_count == 0) begin
            errors++;
            $display("No pattern lines could be read from the pattern file");
        end
        cycle_limit = 20 * line_count + 100;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        fork
            drive_back_pressure();
        join_none
        for (int n = 0; n < line_count; n++) begin
            gap = $urandom_range(2);
            if (gap > 0) begin
                ins_valid <= 1'b0;
                repeat (gap) @(posedge clk);
            end
            ins_valid <= 1'b1;
            ins_word  <= patterns[n*fields];
            ins_pc    <= patterns[n*fields+1];
            @(posedge clk);
            while (!ins_ready) begin
                @(posedge clk);
            end
        end
        ins_valid <= 1'b0;
        while (received < line_count) begin
            @(posedge clk);
        end
        // a short window to catch any stray result.
        repeat (20) @(posedge clk);
        report_and_finish();
    end

endmodule

`default_nettype wire

/* rv32i_slice.f */
src/rv32i_types_pkg.sv
src/rv32i_mux_pkg.sv
src/regfile.sv
src/decode.sv
src/id_ex.sv
src/execute.sv
src/rv32i_slice.sv
testbench/rv32i_slice_tb.sv

/* testbench/rv32i_slice_patterns.txt */
// columns: instruction pc rd value we taken target, all in hex.
// rd and value are compared only when we is 1, target only when taken is 1.
00500093 00000100 01 00000005 1 0 00000000
FFD00113 00000104 02 FFFFFFFD 1 0 00000000
002081B3 00000108 03 00000002 1 0 00000000
40208233 0000010C 04 00000008 1 0 00000000
401152B3 00000110 05 FFFFFFFF 1 0 00000000
00115333 00000114 06 07FFFFFF 1 0 00000000
001123B3 00000118 07 00000001 1 0 00000000
00113433 0000011C 08 00000000 1 0 00000000
0F014493 00000120 09 FFFFFF0D 1 0 00000000
00409513 00000124 0A 00000050 1 0 00000000
40115593 00000128 0B FFFFFFFE 1 0 00000000
FFF5A613 0000012C 0C 00000001 1 0 00000000
00708013 00000130 00 0000000C 1 0 00000000
001006B3 00000134 0D 00000005 1 0 00000000
12345737 00000138 0E 12345000 1 0 00000000
00001797 0000013C 0F 0000113C 1 0 00000000
00D08463 00000140 00 00000000 0 1 00000148
00D09463 00000148 00 00000000 0 0 00000000
00114863 0000014C 00 00000000 0 1 0000015C
00115463 0000015C 00 00000000 0 0 00000000
FE20EAE3 00000160 00 00000000 0 1 00000154
0020F463 00000154 00 00000000 0 0 00000000
0400086F 00000158 10 0000015C 1 1 00000198
001788E7 00000198 11 0000019C 1 1 0000113C
01180933 0000113C 12 000002F8 1 0 00000000
009979B3 00001140 13 00000208 1 0 00000000
8009EA13 00001144 14 FFFFFA08 1 0 00000000
